//--- filelist.f
logic/lsu_pkg.sv
logic/axi_chan_src.sv
logic/lsu_load_extend.sv
logic/lsu_store_port.sv
logic/lsu_load_port.sv
logic/lsu_req_ctrl.sv
logic/lsu_top.sv
testbench/axi_mem_model.sv
testbench/tb_lsu.sv

//--- logic/axi_chan_src.sv
// Valid/ready source register for one AXI address or data channel
`timescale 1ns/10ps
`default_nettype none

module axi_chan_src #(
    parameter type PAYLOAD_T = logic
) (
    input  wire           M_AXI_ACLK,
    input  wire           M_AXI_ARESETN,
    input  wire           i_load,
    input  wire PAYLOAD_T i_payload,
    output logic          o_valid,
    output PAYLOAD_T      o_payload,
    input  wire           i_ready
);

    // Valid flag, dropped once the beat is taken
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            o_valid <= 1'b0;
        end
        else if (i_load)
        begin
            o_valid <= 1'b1;
        end
        else if (o_valid && i_ready)
        begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (i_load)
        begin
            o_payload <= i_payload;
        end
    end

    // ------------------------------
    // Channel rules
    // ------------------------------
    a_hold_until_ready: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_valid && !i_ready |=> o_valid && $stable(o_payload));

    // The owner never reloads a beat the slave has not taken
    a_no_overwrite: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_load |-> !o_valid);

endmodule

`default_nettype wire

//--- logic/lsu_load_extend.sv
// Load extender that picks the accessed bytes of the read word and widens them
`timescale 1ns/10ps
`default_nettype none

module lsu_load_extend
    import lsu_pkg::*;
(
    input  wire [LSU_DATA_W-1:0]  i_rdata,
    input  wire lsu_ld_info_t     i_info,
    output logic [LSU_DATA_W-1:0] o_result
);

    logic [LSU_DATA_W-1:0] shifted;

    // Accessed bytes moved down to lane 0
    assign shifted = i_rdata >> {i_info.offset, 3'b000};

    always_comb
    begin
        logic fill;
        fill = 1'b0;
        case (i_info.size)
            LSU_BYTE:
            begin
                fill     = !i_info.is_unsigned && shifted[7];
                o_result = {{(LSU_DATA_W-8){fill}}, shifted[7:0]};
            end
            LSU_HALF:
            begin
                fill     = !i_info.is_unsigned && shifted[15];
                o_result = {{(LSU_DATA_W-16){fill}}, shifted[15:0]};
            end
            default:
            begin
                o_result = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/lsu_load_port.sv
// Load port driving the AXI4-Lite read address and read data channels
`timescale 1ns/10ps
`default_nettype none

module lsu_load_port
    import lsu_pkg::*;
(
    input  wire                   M_AXI_ACLK,
    input  wire                   M_AXI_ARESETN,
    input  wire                   i_start,
    input  wire axi_addr_t        i_addr,
    output logic                  o_done,
    output logic [LSU_DATA_W-1:0] o_rdata,
    output logic                  o_m_axi_arvalid,
    output logic [LSU_ADDR_W-1:0] o_m_axi_araddr,
    input  wire                   i_m_axi_arready,
    input  wire                   i_m_axi_rvalid,
    input  wire [LSU_DATA_W-1:0]  i_m_axi_rdata,
    output logic                  o_m_axi_rready
);

    axi_addr_t ar_out;
    logic      ld_pend;

    axi_chan_src #(.PAYLOAD_T(axi_addr_t)) u_ar_src (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_load        (i_start),
        .i_payload     (i_addr),
        .o_valid       (o_m_axi_arvalid),
        .o_payload     (ar_out),
        .i_ready       (i_m_axi_arready)
    );

    assign o_m_axi_araddr = ar_out.addr;

    // Outstanding from start until the R beat
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            ld_pend <= 1'b0;
        end
        else if (i_start)
        begin
            ld_pend <= 1'b1;
        end
        else if (o_done)
        begin
            ld_pend <= 1'b0;
        end
    end

    assign o_m_axi_rready = ld_pend;
    assign o_done         = ld_pend && i_m_axi_rvalid;

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (o_done)
        begin
            o_rdata <= i_m_axi_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
// Load/store unit package with bus widths, operation encodings and shared structs
`default_nettype none

package lsu_pkg;

    localparam int LSU_ADDR_W = 32;
    localparam int LSU_DATA_W = 32;
    localparam int LSU_STRB_W = LSU_DATA_W / 8;
    // Byte offset inside one data word
    localparam int LSU_OFFS_W = $clog2(LSU_STRB_W);

    typedef enum logic [1:0] {
        LSU_NONE  = 2'd0,
        LSU_LOAD  = 2'd1,
        LSU_STORE = 2'd2
    } lsu_kind_e;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,
        LSU_HALF = 2'd1,
        LSU_WORD = 2'd2
    } lsu_size_e;

    // Request from the execute stage
    typedef struct packed {
        lsu_kind_e             kind;
        lsu_size_e             size;
        logic                  is_unsigned;
        logic [LSU_ADDR_W-1:0] addr;
        logic [LSU_DATA_W-1:0] wdata;
    } lsu_req_t;

    // AW or AR beat
    typedef struct packed {
        logic [LSU_ADDR_W-1:0] addr;
    } axi_addr_t;

    // W beat
    typedef struct packed {
        logic [LSU_DATA_W-1:0] data;
        logic [LSU_STRB_W-1:0] strb;
    } axi_wdata_t;

    // What the load extender needs from the request
    typedef struct packed {
        lsu_size_e             size;
        logic                  is_unsigned;
        logic [LSU_OFFS_W-1:0] offset;
    } lsu_ld_info_t;

endpackage

`default_nettype wire

//--- logic/lsu_req_ctrl.sv
// Request controller that tracks the single outstanding operation and holds the response
`timescale 1ns/10ps
`default_nettype none

module lsu_req_ctrl
    import lsu_pkg::*;
(
    input  wire                   M_AXI_ACLK,
    input  wire                   M_AXI_ARESETN,
    input  wire                   i_req_valid,
    input  wire lsu_req_t         i_req,
    output logic                  o_req_ready,
    output logic                  o_st_start,
    output logic                  o_ld_start,
    output lsu_req_t              o_req_q,
    input  wire                   i_st_done,
    input  wire                   i_ld_done,
    output lsu_ld_info_t          o_ld_info,
    input  wire [LSU_DATA_W-1:0]  i_ld_result,
    output logic                  o_rsp_valid,
    output logic [LSU_DATA_W-1:0] o_rsp_data,
    input  wire                   i_rsp_ready
);

    logic      busy;
    lsu_kind_e kind_q;
    logic      accept;
    logic      is_mem;

    assign o_req_ready = !busy && !o_rsp_valid;
    assign accept      = i_req_valid && o_req_ready;
    assign is_mem      = (i_req.kind == LSU_LOAD) || (i_req.kind == LSU_STORE);

    // Start goes out in the accept cycle so the bus valids rise one cycle later
    assign o_st_start = accept && (i_req.kind == LSU_STORE);
    assign o_ld_start = accept && (i_req.kind == LSU_LOAD);
    // Request that travels with a start strobe
    assign o_req_q    = i_req;

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            busy        <= 1'b0;
            kind_q      <= LSU_NONE;
            o_rsp_valid <= 1'b0;
        end
        else if (accept)
        begin
            kind_q      <= i_req.kind;
            busy        <= is_mem;
            // Non-memory operation completes at once
            o_rsp_valid <= !is_mem;
        end
        else if (i_st_done || i_ld_done)
        begin
            busy        <= 1'b0;
            o_rsp_valid <= 1'b1;
        end
        else if (o_rsp_valid && i_rsp_ready)
        begin
            o_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (accept)
        begin
            o_ld_info.size        <= i_req.size;
            o_ld_info.is_unsigned <= i_req.is_unsigned;
            o_ld_info.offset      <= i_req.addr[LSU_OFFS_W-1:0];
        end
    end

    // Load port keeps its word until the next R beat, so the result holds
    assign o_rsp_data = (kind_q == LSU_LOAD) ? i_ld_result : '0;

    a_done_when_busy: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (i_st_done || i_ld_done) |-> busy);

endmodule

`default_nettype wire

//--- logic/lsu_store_port.sv
// Store port driving the AXI4-Lite write address, write data and write response channels
`timescale 1ns/10ps
`default_nettype none

module lsu_store_port
    import lsu_pkg::*;
(
    input  wire                   M_AXI_ACLK,
    input  wire                   M_AXI_ARESETN,
    input  wire                   i_start,
    input  wire lsu_req_t         i_req,
    output logic                  o_done,
    output logic                  o_m_axi_awvalid,
    output logic [LSU_ADDR_W-1:0] o_m_axi_awaddr,
    input  wire                   i_m_axi_awready,
    output logic                  o_m_axi_wvalid,
    output logic [LSU_DATA_W-1:0] o_m_axi_wdata,
    output logic [LSU_STRB_W-1:0] o_m_axi_wstrb,
    input  wire                   i_m_axi_wready,
    input  wire                   i_m_axi_bvalid,
    output logic                  o_m_axi_bready
);

    logic [LSU_STRB_W-1:0] strb_base;
    axi_addr_t             aw_in;
    axi_addr_t             aw_out;
    axi_wdata_t            w_in;
    axi_wdata_t            w_out;
    logic                  aw_seen;
    logic                  w_seen;

    // ------------------------------
    // Lane steering
    // ------------------------------
    always_comb
    begin
        case (i_req.size)
            LSU_BYTE: strb_base = LSU_STRB_W'(4'b0001);
            LSU_HALF: strb_base = LSU_STRB_W'(4'b0011);
            default:  strb_base = '1;
        endcase
    end

    assign aw_in.addr = i_req.addr;
    assign w_in.strb  = strb_base << i_req.addr[LSU_OFFS_W-1:0];
    assign w_in.data  = i_req.wdata << {i_req.addr[LSU_OFFS_W-1:0], 3'b000};

    axi_chan_src #(.PAYLOAD_T(axi_addr_t)) u_aw_src (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_load        (i_start),
        .i_payload     (aw_in),
        .o_valid       (o_m_axi_awvalid),
        .o_payload     (aw_out),
        .i_ready       (i_m_axi_awready)
    );

    axi_chan_src #(.PAYLOAD_T(axi_wdata_t)) u_w_src (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_load        (i_start),
        .i_payload     (w_in),
        .o_valid       (o_m_axi_wvalid),
        .o_payload     (w_out),
        .i_ready       (i_m_axi_wready)
    );

    assign o_m_axi_awaddr = aw_out.addr;
    assign o_m_axi_wdata  = w_out.data;
    assign o_m_axi_wstrb  = w_out.strb;

    // ------------------------------
    // Response wait
    // ------------------------------
    // AW and W may be taken in either order
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end
        else if (o_done)
        begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end
        else
        begin
            if (o_m_axi_awvalid && i_m_axi_awready)
            begin
                aw_seen <= 1'b1;
            end
            if (o_m_axi_wvalid && i_m_axi_wready)
            begin
                w_seen <= 1'b1;
            end
        end
    end

    assign o_m_axi_bready = aw_seen && w_seen;
    assign o_done         = o_m_axi_bready && i_m_axi_bvalid;

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
// Load/store unit top joining the request controller, AXI4-Lite ports and load extender
`timescale 1ns/10ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire                   M_AXI_ACLK,
    input  wire                   M_AXI_ARESETN,
    // Execute stage side
    input  wire                   i_req_valid,
    input  wire lsu_req_t         i_req,
    output logic                  o_req_ready,
    // Write-back side
    output logic                  o_rsp_valid,
    output logic [LSU_DATA_W-1:0] o_rsp_data,
    input  wire                   i_rsp_ready,
    // AXI4-Lite master
    output logic                  o_m_axi_awvalid,
    output logic [LSU_ADDR_W-1:0] o_m_axi_awaddr,
    input  wire                   i_m_axi_awready,
    output logic                  o_m_axi_wvalid,
    output logic [LSU_DATA_W-1:0] o_m_axi_wdata,
    output logic [LSU_STRB_W-1:0] o_m_axi_wstrb,
    input  wire                   i_m_axi_wready,
    input  wire                   i_m_axi_bvalid,
    output logic                  o_m_axi_bready,
    output logic                  o_m_axi_arvalid,
    output logic [LSU_ADDR_W-1:0] o_m_axi_araddr,
    input  wire                   i_m_axi_arready,
    input  wire                   i_m_axi_rvalid,
    input  wire [LSU_DATA_W-1:0]  i_m_axi_rdata,
    output logic                  o_m_axi_rready
);

    lsu_req_t              req_fwd;
    lsu_ld_info_t          ld_info;
    axi_addr_t             ld_addr;
    logic                  st_start;
    logic                  ld_start;
    logic                  st_done;
    logic                  ld_done;
    logic [LSU_DATA_W-1:0] ld_word;
    logic [LSU_DATA_W-1:0] ld_result;

    assign ld_addr = '{addr: req_fwd.addr};

    lsu_req_ctrl u_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .o_st_start    (st_start),
        .o_ld_start    (ld_start),
        .o_req_q       (req_fwd),
        .i_st_done     (st_done),
        .i_ld_done     (ld_done),
        .o_ld_info     (ld_info),
        .i_ld_result   (ld_result),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp_data    (o_rsp_data),
        .i_rsp_ready   (i_rsp_ready)
    );

    lsu_store_port u_store (
        .M_AXI_ACLK      (M_AXI_ACLK),
        .M_AXI_ARESETN   (M_AXI_ARESETN),
        .i_start         (st_start),
        .i_req           (req_fwd),
        .o_done          (st_done),
        .o_m_axi_awvalid (o_m_axi_awvalid),
        .o_m_axi_awaddr  (o_m_axi_awaddr),
        .i_m_axi_awready (i_m_axi_awready),
        .o_m_axi_wvalid  (o_m_axi_wvalid),
        .o_m_axi_wdata   (o_m_axi_wdata),
        .o_m_axi_wstrb   (o_m_axi_wstrb),
        .i_m_axi_wready  (i_m_axi_wready),
        .i_m_axi_bvalid  (i_m_axi_bvalid),
        .o_m_axi_bready  (o_m_axi_bready)
    );

    lsu_load_port u_load (
        .M_AXI_ACLK      (M_AXI_ACLK),
        .M_AXI_ARESETN   (M_AXI_ARESETN),
        .i_start         (ld_start),
        .i_addr          (ld_addr),
        .o_done          (ld_done),
        .o_rdata         (ld_word),
        .o_m_axi_arvalid (o_m_axi_arvalid),
        .o_m_axi_araddr  (o_m_axi_araddr),
        .i_m_axi_arready (i_m_axi_arready),
        .i_m_axi_rvalid  (i_m_axi_rvalid),
        .i_m_axi_rdata   (i_m_axi_rdata),
        .o_m_axi_rready  (o_m_axi_rready)
    );

    lsu_load_extend u_extend (
        .i_rdata  (ld_word),
        .i_info   (ld_info),
        .o_result (ld_result)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds and runs the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 --top-module tb_lsu -Mdir "$OBJ" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_lsu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- testbench/axi_mem_model.sv
// AXI4-Lite slave memory of 16 words whose ready and response valid signals stall on a pattern
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model
    import lsu_pkg::*;
(
    input  wire                   M_AXI_ACLK,
    input  wire                   M_AXI_ARESETN,
    input  wire                   i_awvalid,
    input  wire [LSU_ADDR_W-1:0]  i_awaddr,
    output logic                  o_awready,
    input  wire                   i_wvalid,
    input  wire [LSU_DATA_W-1:0]  i_wdata,
    input  wire [LSU_STRB_W-1:0]  i_wstrb,
    output logic                  o_wready,
    output logic                  o_bvalid,
    input  wire                   i_bready,
    input  wire                   i_arvalid,
    input  wire [LSU_ADDR_W-1:0]  i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    output logic [LSU_DATA_W-1:0] o_rdata,
    input  wire                   i_rready
);

    localparam int          MEM_WORDS = 16;
    // One bit per cycle, a zero stalls the channel reading it
    localparam logic [15:0] STALL_PAT = 16'b1001_1101_0010_1110;

    logic [LSU_DATA_W-1:0] mem [MEM_WORDS];
    logic [3:0]            tick;
    logic                  aw_got;
    logic                  w_got;
    logic                  ar_got;
    logic [LSU_ADDR_W-1:0] aw_addr_q;
    logic [LSU_ADDR_W-1:0] ar_addr_q;
    logic [LSU_DATA_W-1:0] w_data_q;
    logic [LSU_STRB_W-1:0] w_strb_q;

    // Each channel reads the pattern at its own phase
    assign o_awready = STALL_PAT[tick] && !aw_got;
    assign o_wready  = STALL_PAT[tick + 4'd5] && !w_got;
    assign o_arready = STALL_PAT[tick + 4'd9] && !ar_got;

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            tick     <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            ar_got   <= 1'b0;
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
            // Fill depends on the byte address of each word
            for (int i = 0; i < MEM_WORDS; i++)
            begin
                mem[i] <= 32'hA5C3_0F96 ^ {4{8'(4 * i)}};
            end
        end
        else
        begin
            tick <= tick + 4'd1;
            // ------------------------------
            // Write side
            // ------------------------------
            if (i_awvalid && o_awready)
            begin
                aw_got    <= 1'b1;
                aw_addr_q <= i_awaddr;
            end
            if (i_wvalid && o_wready)
            begin
                w_got    <= 1'b1;
                w_data_q <= i_wdata;
                w_strb_q <= i_wstrb;
            end
            if (aw_got && w_got && !o_bvalid && STALL_PAT[tick + 4'd3])
            begin
                o_bvalid <= 1'b1;
                for (int k = 0; k < LSU_STRB_W; k++)
                begin
                    if (w_strb_q[k])
                    begin
                        mem[aw_addr_q[5:2]][8 * k +: 8] <= w_data_q[8 * k +: 8];
                    end
                end
            end
            if (o_bvalid && i_bready)
            begin
                o_bvalid <= 1'b0;
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
            end
            // ------------------------------
            // Read side
            // ------------------------------
            if (i_arvalid && o_arready)
            begin
                ar_got    <= 1'b1;
                ar_addr_q <= i_araddr;
            end
            if (ar_got && !o_rvalid && STALL_PAT[tick + 4'd12])
            begin
                o_rvalid <= 1'b1;
                o_rdata  <= mem[ar_addr_q[5:2]];
            end
            if (o_rvalid && i_rready)
            begin
                o_rvalid <= 1'b0;
                ar_got   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_lsu.sv
// Testbench for the load/store unit against a stalling AXI4-Lite memory and a reference memory
`timescale 1ns/10ps
`default_nettype none

module tb_lsu
    import lsu_pkg::*;
();

    localparam int          CLK_NS      = 4;
    localparam int          RST_CYCLES  = 16;
    localparam int          MEM_WORDS   = 16;
    // Fill, read back, two lane rounds, sign round, non-memory ops
    localparam int          NUM_OPS     = 2 * MEM_WORDS + 2 * 8 + 15 + 2;
    localparam int          WATCHDOG_NS = (RST_CYCLES + 40 * NUM_OPS) * CLK_NS;
    localparam logic [15:0] LFSR_SEED   = 16'd54905;

    logic                  M_AXI_ACLK;
    logic                  M_AXI_ARESETN;
    logic                  i_req_valid;
    lsu_req_t              i_req;
    logic                  o_req_ready;
    logic                  o_rsp_valid;
    logic [LSU_DATA_W-1:0] o_rsp_data;
    logic                  i_rsp_ready;
    logic                  o_m_axi_awvalid;
    logic [LSU_ADDR_W-1:0] o_m_axi_awaddr;
    logic                  i_m_axi_awready;
    logic                  o_m_axi_wvalid;
    logic [LSU_DATA_W-1:0] o_m_axi_wdata;
    logic [LSU_STRB_W-1:0] o_m_axi_wstrb;
    logic                  i_m_axi_wready;
    logic                  i_m_axi_bvalid;
    logic                  o_m_axi_bready;
    logic                  o_m_axi_arvalid;
    logic [LSU_ADDR_W-1:0] o_m_axi_araddr;
    logic                  i_m_axi_arready;
    logic                  i_m_axi_rvalid;
    logic [LSU_DATA_W-1:0] i_m_axi_rdata;
    logic                  o_m_axi_rready;

    logic [LSU_DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [15:0]           lfsr_state;
    logic [LSU_ADDR_W-1:0] exp_addr = '0;
    logic [LSU_STRB_W-1:0] exp_strb = '0;
    logic [LSU_DATA_W-1:0] exp_wdata = '0;
    logic [LSU_DATA_W-1:0] exp_wmask = '0;
    logic [LSU_DATA_W-1:0] exp_rsp = '0;
    logic                  chk_rsp = 1'b0;
    logic                  op_pending;
    lsu_kind_e             cur_kind;
    logic                  req_accept;
    int                    value_errors = 0;
    int                    proto_errors = 0;

    lsu_top i_lsu_top (.*);

    axi_mem_model u_mem (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_awvalid     (o_m_axi_awvalid),
        .i_awaddr      (o_m_axi_awaddr),
        .o_awready     (i_m_axi_awready),
        .i_wvalid      (o_m_axi_wvalid),
        .i_wdata       (o_m_axi_wdata),
        .i_wstrb       (o_m_axi_wstrb),
        .o_wready      (i_m_axi_wready),
        .o_bvalid      (i_m_axi_bvalid),
        .i_bready      (o_m_axi_bready),
        .i_arvalid     (o_m_axi_arvalid),
        .i_araddr      (o_m_axi_araddr),
        .o_arready     (i_m_axi_arready),
        .o_rvalid      (i_m_axi_rvalid),
        .o_rdata       (i_m_axi_rdata),
        .i_rready      (o_m_axi_rready)
    );

    initial
    begin
        M_AXI_ACLK = 1'b0;
        forever #(CLK_NS / 2) M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Byte or half picked at the offset, then widened by the unsigned flag
    function automatic logic [31:0] load_value(input logic [31:0] word, input lsu_size_e size,
                                               input logic uns, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = 16'(word >> (8 * off));
        case (size)
            LSU_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
            LSU_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:  return word;
        endcase
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        value_errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    endtask

    task automatic rule_broken(input string what);
        proto_errors++;
        $display("Protocol error at %0t: %s", $time, what);
    endtask

    // Sets the expected values, hands over one request and waits for its response
    task automatic run_op(input lsu_kind_e op_kind, input lsu_size_e op_size, input logic uns,
                          input logic [5:0] addr, input logic [31:0] data);
        logic       accepted;
        logic       taken;
        logic [1:0] off;
        int         nbytes;
        off       = addr[1:0];
        nbytes    = (op_size == LSU_BYTE) ? 1 : (op_size == LSU_HALF) ? 2 : 4;
        exp_addr  = 32'(addr);
        exp_strb  = '0;
        exp_wmask = '0;
        exp_wdata = '0;
        for (int k = 0; k < nbytes; k++)
        begin
            exp_strb[off + k]              = 1'b1;
            exp_wmask[8 * (off + k) +: 8] = 8'hFF;
            exp_wdata[8 * (off + k) +: 8] = data[8 * k +: 8];
        end
        if (op_kind == LSU_STORE)
        begin
            ref_mem[addr[5:2]] = (ref_mem[addr[5:2]] & ~exp_wmask) | exp_wdata;
            chk_rsp = 1'b0;
        end
        else
        begin
            exp_rsp = (op_kind == LSU_LOAD) ? load_value(ref_mem[addr[5:2]], op_size, uns, off)
                                            : '0;
            chk_rsp = 1'b1;
        end
        i_req = '{kind: op_kind, size: op_size, is_unsigned: uns, addr: 32'(addr), wdata: data};
        i_req_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted)
        begin
            accepted = o_req_ready;
            @(posedge M_AXI_ACLK);
            #1;
        end
        i_req_valid = 1'b0;
        taken = 1'b0;
        while (!taken)
        begin
            i_rsp_ready = (rand_bits(2) != 32'd0);
            taken = o_rsp_valid && i_rsp_ready;
            @(posedge M_AXI_ACLK);
            #1;
        end
        i_rsp_ready = 1'b0;
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    assign req_accept = i_req_valid && o_req_ready;

    always @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            op_pending <= 1'b0;
            cur_kind   <= LSU_NONE;
        end
        else if (req_accept)
        begin
            op_pending <= 1'b1;
            cur_kind   <= i_req.kind;
        end
        else if (o_rsp_valid && i_rsp_ready)
        begin
            op_pending <= 1'b0;
        end
    end

    a_reset_idle: assert property (@(posedge M_AXI_ACLK)
        $rose(M_AXI_ARESETN) |-> !o_m_axi_awvalid && !o_m_axi_wvalid && !o_m_axi_bready
            && !o_m_axi_arvalid && !o_m_axi_rready && !o_rsp_valid && o_req_ready)
        else rule_broken("bus or response signals not idle after reset");
    a_aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_awvalid && !i_m_axi_awready |=> o_m_axi_awvalid && $stable(o_m_axi_awaddr))
        else rule_broken("write address changed or dropped before its handshake");
    a_w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_wvalid && !i_m_axi_wready |=> o_m_axi_wvalid && $stable(o_m_axi_wdata)
            && $stable(o_m_axi_wstrb))
        else rule_broken("write data changed or dropped before its handshake");
    a_ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_arvalid && !i_m_axi_arready |=> o_m_axi_arvalid && $stable(o_m_axi_araddr))
        else rule_broken("read address changed or dropped before its handshake");
    a_rsp_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_data))
        else rule_broken("response changed or dropped before it was taken");
    a_ready_low: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        op_pending |-> !o_req_ready)
        else rule_broken("request ready high while an operation is pending");
    a_none_quiet: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        op_pending && cur_kind == LSU_NONE |-> !o_m_axi_awvalid && !o_m_axi_wvalid
            && !o_m_axi_arvalid)
        else rule_broken("bus valid raised for a non-memory operation");
    a_none_rsp: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        req_accept && i_req.kind == LSU_NONE |=> o_rsp_valid)
        else rule_broken("non-memory operation not answered one cycle after accept");
    a_st_issue: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        req_accept && i_req.kind == LSU_STORE |=> o_m_axi_awvalid && o_m_axi_wvalid)
        else rule_broken("store address and data not issued one cycle after accept");
    a_ld_issue: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        req_accept && i_req.kind == LSU_LOAD |=> o_m_axi_arvalid)
        else rule_broken("load address not issued one cycle after accept");

    a_awaddr: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_awvalid |-> o_m_axi_awaddr == exp_addr)
        else value_mismatch("o_m_axi_awaddr", $sampled(o_m_axi_awaddr), exp_addr);
    a_araddr: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_arvalid |-> o_m_axi_araddr == exp_addr)
        else value_mismatch("o_m_axi_araddr", $sampled(o_m_axi_araddr), exp_addr);
    a_wstrb: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_wvalid |-> o_m_axi_wstrb == exp_strb)
        else value_mismatch("o_m_axi_wstrb", 32'($sampled(o_m_axi_wstrb)), 32'(exp_strb));
    // Only the strobed lanes carry store data
    a_wdata: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_m_axi_wvalid |-> (o_m_axi_wdata & exp_wmask) == exp_wdata)
        else value_mismatch("o_m_axi_wdata", $sampled(o_m_axi_wdata) & exp_wmask, exp_wdata);
    a_rsp_data: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        o_rsp_valid && chk_rsp |-> o_rsp_data == exp_rsp)
        else value_mismatch("o_rsp_data", $sampled(o_rsp_data), exp_rsp);

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial
    begin
        logic [3:0] idx;
        M_AXI_ARESETN = 1'b0;
        i_req_valid   = 1'b0;
        i_req         = '0;
        i_rsp_ready   = 1'b0;
        lfsr_state    = LFSR_SEED;
        repeat (RST_CYCLES) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;

        // Known contents in every word, then each read back
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            run_op(LSU_STORE, LSU_WORD, 1'b0, 6'(4 * i), rand_bits(32));
        end
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            run_op(LSU_LOAD, LSU_WORD, 1'b0, 6'(4 * i), '0);
        end

        // Narrow stores at every legal offset, checked by a word load
        for (int r = 0; r < 2; r++)
        begin
            idx = 4'(rand_bits(4));
            for (int off = 0; off < 4; off++)
            begin
                run_op(LSU_STORE, LSU_BYTE, 1'b0, {idx, 2'(off)}, rand_bits(32));
            end
            for (int off = 0; off < 3; off++)
            begin
                run_op(LSU_STORE, LSU_HALF, 1'b0, {idx, 2'(off)}, rand_bits(32));
            end
            run_op(LSU_LOAD, LSU_WORD, 1'b0, {idx, 2'b00}, '0);
        end

        // Bytes and halves of both signs
        idx = 4'(rand_bits(4));
        run_op(LSU_STORE, LSU_WORD, 1'b0, {idx, 2'b00}, 32'h8A7F_C413);
        for (int u = 0; u < 2; u++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                run_op(LSU_LOAD, LSU_BYTE, 1'(u), {idx, 2'(off)}, '0);
            end
            for (int off = 0; off < 3; off++)
            begin
                run_op(LSU_LOAD, LSU_HALF, 1'(u), {idx, 2'(off)}, '0);
            end
        end

        for (int i = 0; i < 2; i++)
        begin
            run_op(LSU_NONE, LSU_WORD, 1'b0, 6'(rand_bits(6)), rand_bits(32));
        end

        repeat (4) @(posedge M_AXI_ACLK);
        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, proto_errors);
        if (value_errors + proto_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with operations still running", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
